// ==== hdl/python_rx_cfg.svh ====
`ifndef PYTHON_RX_CFG_SVH
`define PYTHON_RX_CFG_SVH

// Four data lanes plus one sync lane come from the sensor.
`define PYRX_LANES 4

// Each lane delivers two bits per input beat.
`define PYRX_SER_BITS 2

`define PYRX_WORD_BITS 10

// Word address width of the Wishbone register port.
`define PYRX_WB_AW 3

`endif

// ==== hdl/python_stream_pkg.sv ====
`include "python_rx_cfg.svh"

package python_stream_pkg;

    // One deserialized beat. Lane data plus the sync lane.
    typedef struct packed {
        logic [`PYRX_LANES-1:0][`PYRX_SER_BITS-1:0] data;
        logic [`PYRX_SER_BITS-1:0]                  sync;
    } lane_beat_t;

    typedef struct packed {
        logic [`PYRX_LANES-1:0][`PYRX_WORD_BITS-1:0] data;
        logic [`PYRX_WORD_BITS-1:0]                  sync;
    } aligned_word_t;

    // Control codes carried on the sync lane.
    typedef enum logic [`PYRX_WORD_BITS-1:0] {
        FS  = 10'h2AA,
        LS  = 10'h0AA,
        IMG = 10'h035,
        LE  = 10'h12A,
        FE  = 10'h3AA,
        TR  = 10'h3A6
    } sync_code_t;

    typedef struct packed {
        logic [`PYRX_LANES-1:0][`PYRX_WORD_BITS-1:0] data;
        logic                                        sof;
        logic                                        sol;
        logic                                        eol;
        logic                                        eof;
    } pixel_beat_t;

    typedef struct packed {
        logic frame_end;
        logic line_end;
    } rx_event_t;

endpackage

// ==== hdl/python_reg_pkg.sv ====
`include "python_rx_cfg.svh"

package python_reg_pkg;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`PYRX_WB_AW-1:0] adr;
        logic [31:0]            dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Word addresses of the register map.
    localparam logic [`PYRX_WB_AW-1:0] REG_CTRL    = `PYRX_WB_AW'(0);
    localparam logic [`PYRX_WB_AW-1:0] REG_PATTERN = `PYRX_WB_AW'(1);
    localparam logic [`PYRX_WB_AW-1:0] REG_STATUS  = `PYRX_WB_AW'(2);
    localparam logic [`PYRX_WB_AW-1:0] REG_FRAMES  = `PYRX_WB_AW'(3);
    localparam logic [`PYRX_WB_AW-1:0] REG_LINES   = `PYRX_WB_AW'(4);

    // Bit positions inside REG_CTRL and REG_STATUS.
    localparam int CTRL_SW_RESET_BIT   = 0;
    localparam int STATUS_DONE_BIT     = 0;
    localparam int STATUS_ERROR_BIT    = 1;

    localparam logic CTRL_SW_RESET_INIT = 1'b0;

    // The aligner trains on the sensor's own training word by default.
    localparam logic [`PYRX_WORD_BITS-1:0] PATTERN_INIT = python_stream_pkg::TR;

endpackage

// ==== hdl/python_align_10bit.sv ====
`timescale 1ns/1ps
`include "python_rx_cfg.svh"

module python_align_10bit (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          sw_reset,
    input  logic [`PYRX_WORD_BITS-1:0]    pattern,
    input  python_stream_pkg::lane_beat_t s_beat,
    input  logic                          s_valid,
    output logic                          calib_done,
    output logic                          calib_error,
    output python_stream_pkg::aligned_word_t m_word,
    output logic                          m_valid
);
    import python_stream_pkg::*;

    localparam int BEATS = `PYRX_WORD_BITS / `PYRX_SER_BITS;
    localparam int KEEP  = `PYRX_WORD_BITS - `PYRX_SER_BITS;
    localparam int PW    = $clog2(BEATS);
    localparam logic [PW-1:0] PHASE_LAST = PW'(BEATS - 1);

    aligned_word_t  shift_q;
    aligned_word_t  shift_next;
    logic [PW-1:0]  phase_q;
    logic           detect_q;
    logic           lanes_differ;

    // Newest bits enter at the bottom of every lane.
    always_comb begin
        for (int i = 0; i < `PYRX_LANES; i++) begin
            shift_next.data[i] = {shift_q.data[i][KEEP-1:0], s_beat.data[i]};
        end
        shift_next.sync = {shift_q.sync[KEEP-1:0], s_beat.sync};
    end

    always_comb begin
        lanes_differ = 1'b0;
        for (int i = 1; i < `PYRX_LANES; i++) begin
            if (s_beat.data[i] != s_beat.data[0]) begin
                lanes_differ = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s_valid) begin
            shift_q <= shift_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q     <= '0;
            detect_q    <= 1'b0;
            calib_done  <= 1'b0;
            calib_error <= 1'b0;
            m_valid     <= 1'b0;
        end else if (sw_reset) begin
            phase_q     <= '0;
            detect_q    <= 1'b0;
            calib_done  <= 1'b0;
            calib_error <= 1'b0;
            m_valid     <= 1'b0;
        end else begin
            m_valid <= 1'b0;
            if (s_valid) begin
                detect_q <= (shift_next.data[0] == pattern);
                if (calib_done) begin
                    if (phase_q == PHASE_LAST) begin
                        phase_q <= '0;
                        m_valid <= 1'b1;  // shift_q now holds a whole word.
                    end else begin
                        phase_q <= phase_q + 1'b1;
                    end
                end else if (lanes_differ) begin
                    calib_error <= 1'b1;
                end else if (detect_q && !calib_error) begin
                    // This beat is already the first of the next word.
                    calib_done <= 1'b1;
                    phase_q    <= PW'(1);
                end
            end
        end
    end

    assign m_word = shift_q;

endmodule

// ==== hdl/python_sync_decoder.sv ====
`timescale 1ns/1ps

module python_sync_decoder (
    input  logic                             clk,
    input  logic                             rst_n,
    input  python_stream_pkg::aligned_word_t word,
    input  logic                             word_valid,
    output python_stream_pkg::pixel_beat_t   pix,
    output logic                             pix_valid,
    output python_stream_pkg::rx_event_t     evt
);
    import python_stream_pkg::*;

    sync_code_t  code;
    logic        closes_line;
    pixel_beat_t hold_q;      // IMG word waiting to learn whether it ends a line.
    logic        hold_valid;
    logic        frame_pend;
    logic        line_pend;
    logic        line_open;

    assign code        = sync_code_t'(word.sync);
    assign closes_line = (code == LE) || (code == FE);

    always_ff @(posedge clk) begin
        if (word_valid && hold_valid) begin
            pix     <= hold_q;
            pix.eol <= closes_line;
            pix.eof <= (code == FE);
        end
        if (word_valid && code == IMG) begin
            hold_q.data <= word.data;
            hold_q.sof  <= frame_pend;
            hold_q.sol  <= line_pend;
            hold_q.eol  <= 1'b0;
            hold_q.eof  <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pix_valid  <= 1'b0;
            evt        <= '0;
            hold_valid <= 1'b0;
            frame_pend <= 1'b0;
            line_pend  <= 1'b0;
            line_open  <= 1'b0;
        end else begin
            pix_valid <= word_valid && hold_valid;
            evt       <= '0;
            if (word_valid) begin
                hold_valid <= (code == IMG);
                case (code)
                    FS: begin
                        frame_pend <= 1'b1;
                    end
                    LS: begin
                        line_pend <= 1'b1;
                        line_open <= 1'b1;
                    end
                    IMG: begin
                        frame_pend <= 1'b0;
                        line_pend  <= 1'b0;
                    end
                    LE: begin
                        evt.line_end <= 1'b1;
                        line_open    <= 1'b0;
                    end
                    FE: begin
                        // The last line of a frame ends with FE instead of LE.
                        evt.frame_end <= 1'b1;
                        evt.line_end  <= line_open;
                        line_open     <= 1'b0;
                    end
                    default: begin
                        // Training words and unknown codes carry no pixels.
                    end
                endcase
            end
        end
    end

endmodule

// ==== hdl/python_rx_regs.sv ====
`timescale 1ns/1ps
`include "python_rx_cfg.svh"

module python_rx_regs (
    input  logic                         clk,
    input  logic                         rst_n,
    input  python_reg_pkg::wb_req_t      wb_req,
    input  logic                         calib_done,
    input  logic                         calib_error,
    input  python_stream_pkg::rx_event_t evt,
    output python_reg_pkg::wb_rsp_t      wb_rsp,
    output logic                         sw_reset,
    output logic [`PYRX_WORD_BITS-1:0]   pattern
);
    import python_reg_pkg::*;

    logic        access;
    logic        ack_q;
    logic [31:0] rdata_q;
    logic [31:0] rdata_next;
    logic [31:0] frame_cnt;
    logic [31:0] line_cnt;
    logic [31:0] lines_last;

    // Gating with ack keeps a held strobe from acking twice in a row.
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    always_comb begin
        rdata_next = '0;
        case (wb_req.adr)
            REG_CTRL: begin
                rdata_next[CTRL_SW_RESET_BIT] = sw_reset;
            end
            REG_PATTERN: begin
                rdata_next[`PYRX_WORD_BITS-1:0] = pattern;
            end
            REG_STATUS: begin
                rdata_next[STATUS_DONE_BIT]  = calib_done;
                rdata_next[STATUS_ERROR_BIT] = calib_error;
            end
            REG_FRAMES: begin
                rdata_next = frame_cnt;
            end
            REG_LINES: begin
                rdata_next = lines_last;
            end
            default: begin
                rdata_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (access) begin
            rdata_q <= rdata_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q    <= 1'b0;
            sw_reset <= CTRL_SW_RESET_INIT;
            pattern  <= PATTERN_INIT;
        end else begin
            ack_q <= access;
            if (access && wb_req.we) begin
                case (wb_req.adr)
                    REG_CTRL:    sw_reset <= wb_req.dat[CTRL_SW_RESET_BIT];
                    REG_PATTERN: pattern  <= wb_req.dat[`PYRX_WORD_BITS-1:0];
                    default: begin
                        // Status and counters are read only.
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_cnt  <= '0;
            line_cnt   <= '0;
            lines_last <= '0;
        end else if (evt.frame_end) begin
            frame_cnt  <= frame_cnt + 1'b1;
            lines_last <= line_cnt + 32'(evt.line_end);  // FE may close the last line.
            line_cnt   <= '0;
        end else if (evt.line_end) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rdata_q;

endmodule

// ==== hdl/python_rx_top.sv ====
`timescale 1ns/1ps
`include "python_rx_cfg.svh"

module python_rx_top (
    input  logic                           clk,
    input  logic                           rst_n,
    input  python_stream_pkg::lane_beat_t  rx_beat,
    input  logic                           rx_valid,
    input  python_reg_pkg::wb_req_t        wb_req,
    output python_reg_pkg::wb_rsp_t        wb_rsp,
    output python_stream_pkg::pixel_beat_t pix,
    output logic                           pix_valid
);
    import python_stream_pkg::*;

    aligned_word_t                word;
    logic                         word_valid;
    rx_event_t                    evt;
    logic                         sw_reset;
    logic [`PYRX_WORD_BITS-1:0]   pattern;
    logic                         calib_done;
    logic                         calib_error;

    python_align_10bit u_align (
        .clk         (clk),
        .rst_n       (rst_n),
        .sw_reset    (sw_reset),
        .pattern     (pattern),
        .s_beat      (rx_beat),
        .s_valid     (rx_valid),
        .calib_done  (calib_done),
        .calib_error (calib_error),
        .m_word      (word),
        .m_valid     (word_valid)
    );

    python_sync_decoder u_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .word       (word),
        .word_valid (word_valid),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .evt        (evt)
    );

    python_rx_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_req      (wb_req),
        .calib_done  (calib_done),
        .calib_error (calib_error),
        .evt         (evt),
        .wb_rsp      (wb_rsp),
        .sw_reset    (sw_reset),
        .pattern     (pattern)
    );

endmodule

// ==== tb/python_rx_tb.sv ====
`timescale 1ns/1ps
`include "python_rx_cfg.svh"

module python_rx_tb;
    import python_stream_pkg::*;
    import python_reg_pkg::*;

    localparam string STIM_FILE       = "tb/python_rx_stim.txt";
    localparam int    CYCLES_PER_LINE = 40;
    localparam int    RESET_CYCLES    = 10;

    logic        clk;
    logic        rst_n;
    lane_beat_t  rx_beat;
    logic        rx_valid;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    pixel_beat_t pix;
    logic        pix_valid;

    pixel_beat_t got_q[$];
    pixel_beat_t exp_q[$];
    string       lines_q[$];
    int          line_total = 0;
    int          errors = 0;
    int          err_base = 0;
    int          tests = 0;
    int          tests_failed = 0;

    python_rx_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx_beat   (rx_beat),
        .rx_valid  (rx_valid),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .pix       (pix),
        .pix_valid (pix_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n && pix_valid) begin
            got_q.push_back(pix);
        end
    end

    // Every stim line gets a fixed budget of cycles.
    initial begin
        wait (line_total > 0);
        repeat (line_total * CYCLES_PER_LINE + RESET_CYCLES) @(posedge clk);
        $display("Watchdog expired, the tests took longer than %0d stim lines allow.", line_total);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic note_failure(input string what);
        $display("FAILURE t=%0t %s", $time, what);
        errors++;
    endtask

    task automatic compare_pixel(input pixel_beat_t got, input pixel_beat_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t pix got %h expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic verify_register(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Called on a falling edge and returns on one.
    task automatic drive_beat(input lane_beat_t beat);
        int gap;
        gap = int'($urandom % 3);
        rx_beat  = beat;
        rx_valid = 1'b1;
        @(negedge clk);
        rx_valid = 1'b0;
        repeat (gap) @(negedge clk);
    endtask

    task automatic drive_word(input aligned_word_t word);
        lane_beat_t beat;
        int         top;
        for (int k = 0; k < `PYRX_WORD_BITS / `PYRX_SER_BITS; k++) begin
            top = `PYRX_WORD_BITS - 1 - `PYRX_SER_BITS * k;  // Most significant pair goes first.
            for (int i = 0; i < `PYRX_LANES; i++) begin
                beat.data[i] = word.data[i][top -: `PYRX_SER_BITS];
            end
            beat.sync = word.sync[top -: `PYRX_SER_BITS];
            drive_beat(beat);
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [`PYRX_WB_AW-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        int gap;
        waited = 0;
        gap    = int'($urandom % 4);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdata;
        @(negedge clk);
        while (!wb_rsp.ack && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            note_failure($sformatf("no Wishbone ack for address %0d", adr));
        end
        rdata = wb_rsp.dat;
        @(negedge clk);  // The strobe is still up here and must not be acked again.
        if (wb_rsp.ack) begin
            note_failure($sformatf("second Wishbone ack for address %0d", adr));
        end
        wb_req = '0;
        repeat (gap) @(negedge clk);
    endtask

    // The frame and line counters move on the same cycle as the last pixel beat.
    task automatic wait_pending_pixels();
        int waited;
        waited = 0;
        while (got_q.size() < exp_q.size() && waited < 64) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic close_test(input string name);
        wait_pending_pixels();
        repeat (8) @(negedge clk);  // Late stray beats still land in the queue.
        if (got_q.size() != exp_q.size()) begin
            note_failure($sformatf("test %s collected %0d pixel beats but expected %0d",
                                   name, got_q.size(), exp_q.size()));
        end
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            compare_pixel(got_q.pop_front(), exp_q.pop_front());
        end
        got_q.delete();
        exp_q.delete();
        tests++;
        if (errors == err_base) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, errors - err_base);
        end
        err_base = errors;
    endtask

    task automatic run_line(input string line);
        string         op;
        string         name;
        int            count;
        logic [31:0]   a, b, c, d, e, f;
        logic [31:0]   rdata;
        lane_beat_t    beat;
        aligned_word_t word;
        pixel_beat_t   px;
        if ($sscanf(line, "%s", op) != 1 || op.substr(0, 0) == "#") begin
            return;
        end
        case (op)
            "B": begin
                void'($sscanf(line, "%s %h %h", op, a, b));
                beat.data = a[`PYRX_LANES*`PYRX_SER_BITS-1:0];
                beat.sync = b[`PYRX_SER_BITS-1:0];
                drive_beat(beat);
            end
            "W": begin
                void'($sscanf(line, "%s %d %h %h %h %h %h", op, count, a, b, c, d, e));
                word.sync    = a[`PYRX_WORD_BITS-1:0];
                word.data[0] = b[`PYRX_WORD_BITS-1:0];
                word.data[1] = c[`PYRX_WORD_BITS-1:0];
                word.data[2] = d[`PYRX_WORD_BITS-1:0];
                word.data[3] = e[`PYRX_WORD_BITS-1:0];
                repeat (count) drive_word(word);
            end
            "WR": begin
                void'($sscanf(line, "%s %h %h", op, a, b));
                wb_cycle(1'b1, a[`PYRX_WB_AW-1:0], b, rdata);
            end
            "RD": begin
                void'($sscanf(line, "%s %h %h %s", op, a, b, name));
                wait_pending_pixels();
                wb_cycle(1'b0, a[`PYRX_WB_AW-1:0], '0, rdata);
                verify_register(name, rdata, b);
            end
            "PX": begin
                void'($sscanf(line, "%s %h %h %h %h %h", op, a, b, c, d, f));
                px.data[0] = a[`PYRX_WORD_BITS-1:0];
                px.data[1] = b[`PYRX_WORD_BITS-1:0];
                px.data[2] = c[`PYRX_WORD_BITS-1:0];
                px.data[3] = d[`PYRX_WORD_BITS-1:0];
                {px.sof, px.sol, px.eol, px.eof} = f[3:0];
                exp_q.push_back(px);
            end
            "END": begin
                void'($sscanf(line, "%s %s", op, name));
                close_test(name);
            end
            default: note_failure($sformatf("unknown stim line %s", line));
        endcase
    endtask

    initial begin
        int    fd;
        string line;
        void'($urandom(32'ha628));
        rst_n    = 1'b0;
        rx_beat  = '0;
        rx_valid = 1'b0;
        wb_req   = '0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            note_failure($sformatf("cannot open stimulus file %s", STIM_FILE));
        end else begin
            while ($fgets(line, fd) != 0) begin
                lines_q.push_back(line);
            end
            $fclose(fd);
        end
        line_total = lines_q.size();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        foreach (lines_q[i]) begin
            run_line(lines_q[i]);
        end
        $display("tests %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0 && tests > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/python_rx_stim.txt ====
# B lanes sync | W count sync d0 d1 d2 d3 | WR adr data | RD adr expected name | END test
# PX d0 d1 d2 d3 flags, flags are sof sol eol eof from bit 3 down. All numbers hex, count dec.
RD 1 3A6 pattern
WR 1 FFFFF5A5
RD 1 1A5 pattern
WR 1 3A6
RD 2 0 status
END register_reset
B 00 0
W 2 3A6 3A6 3A6 3A6 3A6
RD 2 1 status
END calibration
WR 0 1
WR 0 0
B 40 0
W 2 3A6 3A6 3A6 3A6 3A6
RD 2 2 status
END lane_error
WR 0 1
WR 0 0
B 00 0
W 2 3A6 3A6 3A6 3A6 3A6
RD 2 1 status
W 1 2AA 000 000 000 000
W 1 0AA 000 000 000 000
W 1 035 001 3FF 155 2AA
W 1 035 0F0 10F 200 04C
W 1 12A 000 000 000 000
W 1 0AA 000 000 000 000
W 1 035 123 234 345 056
W 1 3AA 000 000 000 000
PX 001 3FF 155 2AA C
PX 0F0 10F 200 04C 2
PX 123 234 345 056 7
END pixel_path
RD 3 1 frames
RD 4 2 lines
END counters
WR 0 1
RD 2 0 status
W 2 3A6 3A6 3A6 3A6 3A6
W 1 035 3FF 3FF 3FF 3FF
W 1 3AA 000 000 000 000
END sw_reset_hold
WR 0 0
B 00 0
W 2 3A6 3A6 3A6 3A6 3A6
W 1 2AA 000 000 000 000
W 1 035 2C5 1D4 0E3 3F2
W 1 3AA 000 000 000 000
PX 2C5 1D4 0E3 3F2 B
RD 3 2 frames
RD 4 0 lines
END sw_reset_release

// ==== compile.f ====
+incdir+hdl
hdl/python_stream_pkg.sv
hdl/python_reg_pkg.sv
hdl/python_align_10bit.sv
hdl/python_sync_decoder.sv
hdl/python_rx_regs.sv
hdl/python_rx_top.sv
tb/python_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the receiver testbench with Verilator and runs it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module python_rx_tb \
    -f compile.f -o python_rx_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed."
    exit 1
fi

./obj_dir/python_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status."
    exit 1
fi

if grep -q "SIMULATION FAILED" sim.log; then
    exit 1
fi
exit 0
